// File: rtl/fpga_svc_macros.svh
`ifndef FPGA_SVC_MACROS_SVH
`define FPGA_SVC_MACROS_SVH

// Bus word width
`define SVC_DATA_W 32

// Decoded register address bits, byte offsets 0x00 to 0x1C
`define SVC_ADDR_W 5

// Log character FIFO entries
`define LOG_DEPTH 16

// TRNG word FIFO entries
`define ITRNG_DEPTH 8

// Nibbles handed out per TRNG word
`define NIBBLES_PER_WORD 8

`endif

// File: rtl/fpga_svc_pkg.sv
`include "fpga_svc_macros.svh"

package fpga_svc_pkg;

    typedef logic [`SVC_DATA_W-1:0] word_t;
    typedef logic [7:0]             char_t;   // One log character
    typedef logic [3:0]             nibble_t; // One TRNG nibble

    // Service register map, byte offsets
    typedef enum logic [`SVC_ADDR_W-1:0] {
        REG_CONTROL      = 5'h00, // bit0 core_rst_b, bit1 core_pwrgood
        REG_ITRNG_DIV    = 5'h04,
        REG_CYCLE_COUNT  = 5'h08, // Read only
        REG_LOG_DATA     = 5'h0C, // Read pops the log FIFO
        REG_LOG_STATUS   = 5'h10,
        REG_ITRNG_DATA   = 5'h14, // Write pushes a word
        REG_ITRNG_STATUS = 5'h18  // bit2 write flushes
    } reg_addr_e;

    // Per-channel AXI-Lite state
    typedef enum logic {
        AXIL_IDLE,
        AXIL_RESP
    } axil_state_e;

    typedef enum logic [1:0] {
        RESP_OKAY = 2'b00
    } axi_resp_e;

endpackage

// File: rtl/svc_fifo_if.sv
`timescale 1ns/1ps

// Register block view of the log character FIFO
interface log_fifo_if;
    fpga_svc_pkg::char_t head;
    logic                empty;
    logic                full;
    logic                pop; // One cycle per accepted data read

    modport regs (input head, input empty, input full, output pop);
    modport fifo (output head, output empty, output full, input pop);
endinterface

// Register block view of the TRNG feeder
interface itrng_fifo_if;
    logic                push;
    fpga_svc_pkg::word_t push_word;
    logic                flush;
    fpga_svc_pkg::word_t divisor; // Throttle reload value
    logic                empty;
    logic                full;

    modport regs (
        output push, output push_word, output flush, output divisor,
        input empty, input full
    );
    modport feeder (
        input push, input push_word, input flush, input divisor,
        output empty, output full
    );
endinterface

// File: rtl/log_char_fifo.sv
`timescale 1ns/1ps
`include "fpga_svc_macros.svh"

module log_char_fifo (
    input  logic                core_clk,
    input  logic                hwif_out,
    input  logic                log_char_valid,
    input  fpga_svc_pkg::char_t log_char,
    log_fifo_if.fifo            log
);

    localparam int PTR_W = $clog2(`LOG_DEPTH);

    fpga_svc_pkg::char_t mem [`LOG_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [PTR_W:0]      count;
    logic                do_push;
    logic                do_pop;

    assign log.empty = (count == '0);
    assign log.full  = (count == (PTR_W+1)'(`LOG_DEPTH));

    // Characters arriving while full are lost
    assign do_push = log_char_valid && !log.full;
    assign do_pop  = log.pop && !log.empty; // Pop on empty is ignored

    // Fall-through head
    assign log.head = mem[rd_ptr];

    always_ff @(posedge core_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= log_char;
        end
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: rtl/itrng_feeder.sv
`timescale 1ns/1ps
`include "fpga_svc_macros.svh"

module itrng_feeder (
    input  logic                  core_clk,
    input  logic                  hwif_out,
    input  logic                  etrng_req,
    output logic                  itrng_valid,
    output fpga_svc_pkg::nibble_t itrng_data,
    itrng_fifo_if.feeder          itrng
);

    localparam int PTR_W = $clog2(`ITRNG_DEPTH);
    localparam int NIB_W = $clog2(`NIBBLES_PER_WORD);
    localparam int NIB_BITS = $bits(fpga_svc_pkg::nibble_t);
    localparam logic [NIB_W-1:0] LAST_NIB = NIB_W'(`NIBBLES_PER_WORD - 1);

    fpga_svc_pkg::word_t mem [`ITRNG_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [PTR_W:0]      count;
    logic [NIB_W-1:0]    nib_idx;  // Next nibble of the oldest word
    fpga_svc_pkg::word_t div_cnt;  // Throttle down-counter
    logic                do_push;
    logic                grant;
    logic                retire;

    assign itrng.empty = (count == '0);
    assign itrng.full  = (count == (PTR_W+1)'(`ITRNG_DEPTH));

    // Push while full is dropped here
    assign do_push = itrng.push && !itrng.full && !itrng.flush;

    // One nibble per zero count, only with a request and data on hand
    assign grant  = (div_cnt == '0) && etrng_req && !itrng.empty && !itrng.flush;
    assign retire = grant && (nib_idx == LAST_NIB);

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            div_cnt <= '0;
        end else if (div_cnt == '0) begin
            div_cnt <= itrng.divisor; // Reload on the zero cycle
        end else begin
            div_cnt <= div_cnt - 1'b1;
        end
    end

    always_ff @(posedge core_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= itrng.push_word;
        end
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            nib_idx <= '0;
        end else if (itrng.flush) begin
            // Drop all words and restart at nibble 0
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            nib_idx <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (grant) begin
                nib_idx <= retire ? '0 : nib_idx + 1'b1;
            end
            if (retire) begin
                rd_ptr <= rd_ptr + 1'b1; // Word fully consumed
            end
            case ({do_push, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Valid pulse one cycle after the grant
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            itrng_valid <= 1'b0;
        end else begin
            itrng_valid <= grant;
        end
    end

    // Lowest nibble first
    always_ff @(posedge core_clk) begin
        if (grant) begin
            itrng_data <= mem[rd_ptr][{nib_idx, 2'b00} +: NIB_BITS];
        end
    end

endmodule

// File: rtl/svc_regs.sv
`timescale 1ns/1ps
`include "fpga_svc_macros.svh"

module svc_regs (
    input  logic                    core_clk,
    input  logic                    hwif_out,
    input  logic                    s_awvalid,
    output logic                    s_awready,
    input  logic [`SVC_ADDR_W-1:0]  s_awaddr,
    input  logic                    s_wvalid,
    output logic                    s_wready,
    input  fpga_svc_pkg::word_t     s_wdata,
    output logic                    s_bvalid,
    input  logic                    s_bready,
    output fpga_svc_pkg::axi_resp_e s_bresp,
    input  logic                    s_arvalid,
    output logic                    s_arready,
    input  logic [`SVC_ADDR_W-1:0]  s_araddr,
    output logic                    s_rvalid,
    input  logic                    s_rready,
    output fpga_svc_pkg::word_t     s_rdata,
    output fpga_svc_pkg::axi_resp_e s_rresp,
    output logic                    core_rst_b,
    output logic                    core_pwrgood,
    log_fifo_if.regs                log,
    itrng_fifo_if.regs              itrng
);

    fpga_svc_pkg::axil_state_e wr_state;
    fpga_svc_pkg::axil_state_e rd_state;
    fpga_svc_pkg::reg_addr_e   wr_addr;
    fpga_svc_pkg::reg_addr_e   rd_addr;
    logic                      wr_accept;
    logic                      rd_accept;
    logic [1:0]                ctrl;        // {pwrgood, rst_b}
    fpga_svc_pkg::word_t       divisor;
    fpga_svc_pkg::word_t       cycle_count;
    fpga_svc_pkg::word_t       rd_mux;

    assign wr_addr = fpga_svc_pkg::reg_addr_e'(s_awaddr);
    assign rd_addr = fpga_svc_pkg::reg_addr_e'(s_araddr);

    // Address and data taken together, only with no response pending
    assign wr_accept = (wr_state == fpga_svc_pkg::AXIL_IDLE) && s_awvalid && s_wvalid;
    assign s_awready = wr_accept;
    assign s_wready  = wr_accept;
    assign s_bvalid  = (wr_state == fpga_svc_pkg::AXIL_RESP);
    assign s_bresp   = fpga_svc_pkg::RESP_OKAY;

    assign rd_accept = (rd_state == fpga_svc_pkg::AXIL_IDLE) && s_arvalid;
    assign s_arready = rd_accept;
    assign s_rvalid  = (rd_state == fpga_svc_pkg::AXIL_RESP);
    assign s_rresp   = fpga_svc_pkg::RESP_OKAY;

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_state <= fpga_svc_pkg::AXIL_IDLE;
        end else if (wr_accept) begin
            wr_state <= fpga_svc_pkg::AXIL_RESP;
        end else if (s_bvalid && s_bready) begin
            wr_state <= fpga_svc_pkg::AXIL_IDLE;
        end
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            rd_state <= fpga_svc_pkg::AXIL_IDLE;
        end else if (rd_accept) begin
            rd_state <= fpga_svc_pkg::AXIL_RESP;
        end else if (s_rvalid && s_rready) begin
            rd_state <= fpga_svc_pkg::AXIL_IDLE;
        end
    end

    // Writable registers, other offsets ignored
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            ctrl    <= '0;
            divisor <= '0;
        end else if (wr_accept) begin
            case (wr_addr)
                fpga_svc_pkg::REG_CONTROL:   ctrl    <= s_wdata[1:0];
                fpga_svc_pkg::REG_ITRNG_DIV: divisor <= s_wdata;
                default: ;
            endcase
        end
    end

    assign core_rst_b   = ctrl[0];
    assign core_pwrgood = ctrl[1];

    // Held at zero while the core sits in reset
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            cycle_count <= '0;
        end else if (!ctrl[0]) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    // Side-effect strobes toward the FIFOs
    assign log.pop         = rd_accept && (rd_addr == fpga_svc_pkg::REG_LOG_DATA);
    assign itrng.push      = wr_accept && (wr_addr == fpga_svc_pkg::REG_ITRNG_DATA);
    assign itrng.push_word = s_wdata;
    assign itrng.flush     = wr_accept && (wr_addr == fpga_svc_pkg::REG_ITRNG_STATUS)
                             && s_wdata[2];
    assign itrng.divisor   = divisor;

    always_comb begin
        case (rd_addr)
            fpga_svc_pkg::REG_CONTROL:      rd_mux = fpga_svc_pkg::word_t'(ctrl);
            fpga_svc_pkg::REG_ITRNG_DIV:    rd_mux = divisor;
            fpga_svc_pkg::REG_CYCLE_COUNT:  rd_mux = cycle_count;
            fpga_svc_pkg::REG_LOG_DATA:     rd_mux = fpga_svc_pkg::word_t'({!log.empty, log.head});
            fpga_svc_pkg::REG_LOG_STATUS:   rd_mux = fpga_svc_pkg::word_t'({log.full, log.empty});
            fpga_svc_pkg::REG_ITRNG_STATUS:
                rd_mux = fpga_svc_pkg::word_t'({itrng.full, itrng.empty});
            default:                        rd_mux = '0; // Unmapped and write-only
        endcase
    end

    // Captured on the same edge as the pop
    always_ff @(posedge core_clk) begin
        if (rd_accept) begin
            s_rdata <= rd_mux;
        end
    end

endmodule

// File: rtl/fpga_svc_top.sv
`timescale 1ns/1ps
`include "fpga_svc_macros.svh"

module fpga_svc_top (
    input  logic                    core_clk,
    input  logic                    hwif_out,
    input  logic                    s_awvalid,
    output logic                    s_awready,
    input  logic [`SVC_ADDR_W-1:0]  s_awaddr,
    input  logic                    s_wvalid,
    output logic                    s_wready,
    input  fpga_svc_pkg::word_t     s_wdata,
    output logic                    s_bvalid,
    input  logic                    s_bready,
    output fpga_svc_pkg::axi_resp_e s_bresp,
    input  logic                    s_arvalid,
    output logic                    s_arready,
    input  logic [`SVC_ADDR_W-1:0]  s_araddr,
    output logic                    s_rvalid,
    input  logic                    s_rready,
    output fpga_svc_pkg::word_t     s_rdata,
    output fpga_svc_pkg::axi_resp_e s_rresp,
    input  logic                    log_char_valid,
    input  fpga_svc_pkg::char_t     log_char,
    input  logic                    etrng_req,
    output logic                    itrng_valid,
    output fpga_svc_pkg::nibble_t   itrng_data,
    output logic                    core_rst_b,
    output logic                    core_pwrgood
);

    log_fifo_if   log_if ();
    itrng_fifo_if itrng_if ();

    svc_regs u_regs (
        .core_clk     (core_clk),
        .hwif_out     (hwif_out),
        .s_awvalid    (s_awvalid),
        .s_awready    (s_awready),
        .s_awaddr     (s_awaddr),
        .s_wvalid     (s_wvalid),
        .s_wready     (s_wready),
        .s_wdata      (s_wdata),
        .s_bvalid     (s_bvalid),
        .s_bready     (s_bready),
        .s_bresp      (s_bresp),
        .s_arvalid    (s_arvalid),
        .s_arready    (s_arready),
        .s_araddr     (s_araddr),
        .s_rvalid     (s_rvalid),
        .s_rready     (s_rready),
        .s_rdata      (s_rdata),
        .s_rresp      (s_rresp),
        .core_rst_b   (core_rst_b),
        .core_pwrgood (core_pwrgood),
        .log          (log_if.regs),
        .itrng        (itrng_if.regs)
    );

    // Character source from the core side
    log_char_fifo u_log_fifo (
        .core_clk       (core_clk),
        .hwif_out       (hwif_out),
        .log_char_valid (log_char_valid),
        .log_char       (log_char),
        .log            (log_if.fifo)
    );

    itrng_feeder u_itrng (
        .core_clk    (core_clk),
        .hwif_out    (hwif_out),
        .etrng_req   (etrng_req),
        .itrng_valid (itrng_valid),
        .itrng_data  (itrng_data),
        .itrng       (itrng_if.feeder)
    );

endmodule

// File: tb/svc_properties.sv
`timescale 1ns/1ps

module svc_properties (
    input logic                core_clk,
    input logic                hwif_out,
    input logic                bvalid,
    input logic                bready,
    input logic                rvalid,
    input logic                rready,
    input fpga_svc_pkg::word_t rdata,
    input logic                pop,
    input logic                empty,
    input logic                push,
    input logic                nib_valid,
    input fpga_svc_pkg::word_t divisor
);

    assert property (@(posedge core_clk) disable iff (!hwif_out)
        bvalid && !bready |=> bvalid)
        else $error("s_bvalid dropped before s_bready");

    // Read data frozen under back-pressure
    assert property (@(posedge core_clk) disable iff (!hwif_out)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("s_rvalid or s_rdata changed before s_rready");

    // Pop on an empty FIFO is ignored, so it stays empty
    assert property (@(posedge core_clk) disable iff (!hwif_out)
        pop && empty && !push |=> empty)
        else $error("Pop on empty log FIFO changed its state");

    assert property (@(posedge core_clk) disable iff (!hwif_out)
        nib_valid && (divisor != '0) |=> !nib_valid)
        else $error("itrng_valid longer than one cycle with throttle on");

endmodule

bind svc_regs svc_properties u_bus_props (
    .core_clk (core_clk),
    .hwif_out (hwif_out),
    .bvalid   (s_bvalid),
    .bready   (s_bready),
    .rvalid   (s_rvalid),
    .rready   (s_rready),
    .rdata    (s_rdata),
    .pop      (1'b0),
    .empty    (1'b0),
    .push     (1'b0),
    .nib_valid(1'b0),
    .divisor  ('0)
);

bind log_char_fifo svc_properties u_log_props (
    .core_clk (core_clk),
    .hwif_out (hwif_out),
    .bvalid   (1'b0),
    .bready   (1'b1),
    .rvalid   (1'b0),
    .rready   (1'b1),
    .rdata    ('0),
    .pop      (log.pop),
    .empty    (log.empty),
    .push     (log_char_valid),
    .nib_valid(1'b0),
    .divisor  ('0)
);

bind itrng_feeder svc_properties u_feeder_props (
    .core_clk (core_clk),
    .hwif_out (hwif_out),
    .bvalid   (1'b0),
    .bready   (1'b1),
    .rvalid   (1'b0),
    .rready   (1'b1),
    .rdata    ('0),
    .pop      (1'b0),
    .empty    (1'b0),
    .push     (1'b0),
    .nib_valid(itrng_valid),
    .divisor  (itrng.divisor)
);

// File: tb/tb_fpga_svc.sv
`timescale 1ns/1ps
`include "fpga_svc_macros.svh"

module tb_fpga_svc;

    // Rough cycle budget per test, in test order
    localparam int PLAN_CYCLES = 30 + 40 + 120 + 60 + 80 + 60;

    logic                    core_clk;
    logic                    hwif_out;
    logic                    s_awvalid, s_awready, s_wvalid, s_wready;
    logic [`SVC_ADDR_W-1:0]  s_awaddr, s_araddr;
    fpga_svc_pkg::word_t     s_wdata, s_rdata;
    logic                    s_bvalid, s_bready, s_arvalid, s_arready;
    logic                    s_rvalid, s_rready;
    fpga_svc_pkg::axi_resp_e s_bresp, s_rresp;
    logic                    log_char_valid;
    fpga_svc_pkg::char_t     log_char;
    logic                    etrng_req, itrng_valid;
    fpga_svc_pkg::nibble_t   itrng_data;
    logic                    core_rst_b, core_pwrgood;

    int                      errors;
    fpga_svc_pkg::word_t     rng_state;
    fpga_svc_pkg::nibble_t   nib_got [16];
    longint                  pulse_t [16];

    fpga_svc_top dut0 (.*);

    initial begin
        core_clk = 1'b0;
        forever #5 core_clk = ~core_clk;
    end

    initial begin
        #(PLAN_CYCLES * 4 * 10);
        errors++;
        $display("Timeout: the tests did not finish within the cycle budget");
        $display("Errors: %0d", errors);
        $display("Result: FAILED");
        $finish;
    end

    function automatic fpga_svc_pkg::word_t xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_word(input fpga_svc_pkg::word_t got, input fpga_svc_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_char(input fpga_svc_pkg::char_t got, input fpga_svc_pkg::char_t exp,
                              input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_nibble(input fpga_svc_pkg::nibble_t got,
                                input fpga_svc_pkg::nibble_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_resp(input fpga_svc_pkg::axi_resp_e got, input string what);
        if (got !== fpga_svc_pkg::RESP_OKAY) begin
            errors++;
            $display("Fail at %0t: %s response %b is not OKAY", $time, what, got);
        end
    endtask

    // Valid held until the slave takes it, then the response is held back a cycle
    task automatic axil_write(input logic [`SVC_ADDR_W-1:0] addr,
                              input fpga_svc_pkg::word_t data);
        int   n;
        logic taken;
        @(negedge core_clk);
        s_awaddr  = addr;
        s_wdata   = data;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        s_bready  = 1'b0;
        n     = 0;
        taken = 1'b0;
        while (!taken && n < 20) begin
            #1;
            taken = s_awready && s_wready; // Ready rises in the same cycle as valid
            @(negedge core_clk);
            n++;
        end
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        while (!s_bvalid && n < 20) begin
            @(negedge core_clk);
            n++;
        end
        if (!taken) begin
            errors++;
            $display("Write to offset %h was never accepted", addr);
        end else if (!s_bvalid) begin
            errors++;
            $display("Write to offset %h got no response", addr);
        end else begin
            check_resp(s_bresp, "write");
            @(negedge core_clk);
            if (!s_bvalid) begin
                errors++;
                $display("Fail at %0t: write response to offset %h dropped before s_bready",
                         $time, addr);
            end
        end
        s_bready = 1'b1;
    endtask

    task automatic axil_read(input logic [`SVC_ADDR_W-1:0] addr,
                             output fpga_svc_pkg::word_t data,
                             output fpga_svc_pkg::axi_resp_e resp);
        int   n;
        logic taken;
        @(negedge core_clk);
        s_araddr  = addr;
        s_arvalid = 1'b1;
        s_rready  = 1'b0;
        n     = 0;
        taken = 1'b0;
        while (!taken && n < 20) begin
            #1;
            taken = s_arready;
            @(negedge core_clk);
            n++;
        end
        s_arvalid = 1'b0;
        while (!s_rvalid && n < 20) begin
            @(negedge core_clk);
            n++;
        end
        data = s_rdata;
        resp = s_rresp;
        if (!taken) begin
            errors++;
            $display("Read from offset %h was never accepted", addr);
        end else if (!s_rvalid) begin
            errors++;
            $display("Read from offset %h got no response", addr);
        end else begin
            @(negedge core_clk); // One cycle of back-pressure
            if (!s_rvalid || s_rdata !== data) begin
                errors++;
                $display("Fail at %0t: read response from offset %h changed before s_rready",
                         $time, addr);
            end
        end
        s_rready = 1'b1;
    endtask

    task automatic read_expect(input logic [`SVC_ADDR_W-1:0] addr,
                               input fpga_svc_pkg::word_t exp, input string what);
        fpga_svc_pkg::word_t     data;
        fpga_svc_pkg::axi_resp_e resp;
        axil_read(addr, data, resp);
        check_word(data, exp, what);
        check_resp(resp, what);
    endtask

    task automatic collect_pulses(input int n, input int limit);
        int got;
        int waited;
        got    = 0;
        waited = 0;
        while (got < n && waited < limit) begin
            @(negedge core_clk);
            waited++;
            if (itrng_valid) begin
                nib_got[got] = itrng_data;
                pulse_t[got] = $time;
                got++;
            end
        end
        if (got < n) begin
            errors++;
            $display("Only %0d of %0d TRNG nibbles arrived", got, n);
        end
    endtask

    task automatic test_control();
        read_expect(fpga_svc_pkg::REG_CONTROL, 32'h0, "control after reset");
        check_word(fpga_svc_pkg::word_t'({core_pwrgood, core_rst_b}), 32'h0, "core outputs");
        axil_write(fpga_svc_pkg::REG_CONTROL, 32'h3);
        check_word(fpga_svc_pkg::word_t'({core_pwrgood, core_rst_b}), 32'h3, "core outputs");
        read_expect(fpga_svc_pkg::REG_CONTROL, 32'h3, "control readback");
        read_expect(5'h1C, 32'h0, "unmapped offset");
    endtask

    task automatic test_cycle_count();
        fpga_svc_pkg::word_t     first;
        fpga_svc_pkg::word_t     second;
        fpga_svc_pkg::axi_resp_e resp;
        axil_write(fpga_svc_pkg::REG_CONTROL, 32'h0);
        read_expect(fpga_svc_pkg::REG_CYCLE_COUNT, 32'h0, "count in core reset");
        axil_write(fpga_svc_pkg::REG_CONTROL, 32'h1);
        axil_read(fpga_svc_pkg::REG_CYCLE_COUNT, first, resp);
        axil_read(fpga_svc_pkg::REG_CYCLE_COUNT, second, resp);
        if (second <= first) begin
            errors++;
            $display("Fail at %0t: cycle count %0d not above %0d", $time, second, first);
        end
        axil_write(fpga_svc_pkg::REG_CONTROL, 32'h0);
        read_expect(fpga_svc_pkg::REG_CYCLE_COUNT, 32'h0, "count cleared");
    endtask

    task automatic test_log_fifo();
        fpga_svc_pkg::char_t     chars [20];
        fpga_svc_pkg::word_t     data;
        fpga_svc_pkg::axi_resp_e resp;
        for (int i = 0; i < 20; i++) begin
            @(negedge core_clk);
            chars[i]       = fpga_svc_pkg::char_t'(xorshift32());
            log_char       = chars[i];
            log_char_valid = 1'b1;
        end
        @(negedge core_clk);
        log_char_valid = 1'b0;
        read_expect(fpga_svc_pkg::REG_LOG_STATUS, 32'h2, "log status full");
        // Last four pushes hit a full FIFO and are lost
        for (int i = 0; i < 16; i++) begin
            axil_read(fpga_svc_pkg::REG_LOG_DATA, data, resp);
            check_word(data & 32'h100, 32'h100, "log valid bit");
            check_char(data[7:0], chars[i], "log character");
        end
        axil_read(fpga_svc_pkg::REG_LOG_DATA, data, resp);
        check_word(data & 32'h100, 32'h0, "log valid bit when empty");
        read_expect(fpga_svc_pkg::REG_LOG_STATUS, 32'h1, "log status empty");
    endtask

    task automatic test_nibble_order();
        fpga_svc_pkg::word_t words [2];
        words[0] = xorshift32();
        words[1] = xorshift32();
        axil_write(fpga_svc_pkg::REG_ITRNG_DIV, 32'h0);
        etrng_req = 1'b1;
        fork
            begin
                axil_write(fpga_svc_pkg::REG_ITRNG_DATA, words[0]);
                axil_write(fpga_svc_pkg::REG_ITRNG_DATA, words[1]);
            end
            collect_pulses(16, 100);
        join
        for (int k = 0; k < 16; k++) begin
            check_nibble(nib_got[k], words[k / 8][(k % 8) * 4 +: 4], "nibble order");
        end
        read_expect(fpga_svc_pkg::REG_ITRNG_STATUS, 32'h1, "TRNG status empty");
    endtask

    task automatic test_throttle();
        fpga_svc_pkg::word_t word;
        longint              gap;
        word = xorshift32();
        axil_write(fpga_svc_pkg::REG_ITRNG_DIV, 32'd5);
        axil_write(fpga_svc_pkg::REG_ITRNG_DATA, word);
        collect_pulses(8, 120);
        for (int k = 0; k < 8; k++) begin
            check_nibble(nib_got[k], word[k * 4 +: 4], "throttled nibble");
        end
        for (int k = 1; k < 8; k++) begin
            gap = (pulse_t[k] - pulse_t[k - 1]) / 10;
            if (gap < 6) begin
                errors++;
                $display("Fail at %0t: pulse spacing %0d cycles, below 6", $time, gap);
            end
        end
    endtask

    task automatic test_flush();
        int pulses;
        etrng_req = 1'b0;
        for (int i = 0; i < 3; i++) begin
            axil_write(fpga_svc_pkg::REG_ITRNG_DATA, xorshift32());
        end
        read_expect(fpga_svc_pkg::REG_ITRNG_STATUS, 32'h0, "TRNG status holding words");
        axil_write(fpga_svc_pkg::REG_ITRNG_STATUS, 32'h4);
        read_expect(fpga_svc_pkg::REG_ITRNG_STATUS, 32'h1, "TRNG status after flush");
        etrng_req = 1'b1;
        pulses = 0;
        repeat (30) begin
            @(negedge core_clk);
            if (itrng_valid) pulses++;
        end
        check_word(fpga_svc_pkg::word_t'(pulses), 32'h0, "pulses after flush");
        etrng_req = 1'b0;
    endtask

    initial begin
        errors         = 0;
        rng_state      = 32'd27;
        hwif_out       = 1'b0;
        s_awvalid      = 1'b0;
        s_awaddr       = '0;
        s_wvalid       = 1'b0;
        s_wdata        = '0;
        s_bready       = 1'b1;
        s_arvalid      = 1'b0;
        s_araddr       = '0;
        s_rready       = 1'b1;
        log_char_valid = 1'b0;
        log_char       = '0;
        etrng_req      = 1'b0;
        repeat (3) @(negedge core_clk);
        hwif_out = 1'b1;

        test_control();
        test_cycle_count();
        test_log_fifo();
        test_nibble_order();
        test_throttle();
        test_flush();

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+rtl
rtl/fpga_svc_pkg.sv
rtl/svc_fifo_if.sv
rtl/log_char_fifo.sv
rtl/itrng_feeder.sv
rtl/svc_regs.sv
rtl/fpga_svc_top.sv
tb/svc_properties.sv
tb/tb_fpga_svc.sv

// File: Makefile
TOP := tb_fpga_svc
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Result: PASSED" $(LOG) || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
